// File: source/bus_pkg.sv
// bus widths and request/response structs shared by the APB bridge, request FIFO and register bank
package bus_pkg;

  // **********************************************************************
  // bus widths
  // **********************************************************************

  localparam int unsigned BUS_ADDR_W = 32;
  localparam int unsigned BUS_DATA_W = 32;
  localparam int unsigned BUS_BE_W   = BUS_DATA_W / 8;

  // **********************************************************************
  // word request, one per APB transfer
  // **********************************************************************

  typedef struct packed {
    logic [BUS_ADDR_W-1:0] addr;
    logic                  we;
    logic [BUS_BE_W-1:0]   be;
    logic [BUS_DATA_W-1:0] wdata;
  } per_req_t;

  // response returned by the bank
  typedef struct packed {
    logic [BUS_DATA_W-1:0] rdata;
    logic                  err;
  } per_resp_t;

endpackage

// File: source/dbg_pkg.sv
// debug register map and hart-info word definitions used by the register bank and its testbench
package dbg_pkg;

  // **********************************************************************
  // register map, byte addresses
  // **********************************************************************

  localparam logic [31:0] DATA_BASE_ADDR = 32'h0000_0000;
  localparam logic [31:0] HARTINFO_ADDR  = 32'h0000_0040;

  // where the data registers sit in the hart's memory map
  localparam logic [11:0] DM_DATA_ADDR = 12'h380;

  // **********************************************************************
  // hart-info word
  // **********************************************************************

  typedef struct packed {
    logic [7:0]  zero1;
    logic [3:0]  nscratch;
    logic [2:0]  zero0;
    logic        dataaccess;
    logic [3:0]  datasize;
    logic [11:0] dataaddr;
  } hartinfo_fields_t;

  // same word, seen as fields or as the raw bus value
  typedef union packed {
    hartinfo_fields_t fields;
    logic [31:0]      raw;
  } hartinfo_u;

  // two scratch regs, data regs memory mapped
  localparam hartinfo_fields_t HARTINFO_FIELDS = '{
    zero1:      8'h00,
    nscratch:   4'd2,
    zero0:      3'd0,
    dataaccess: 1'b1,
    datasize:   4'd2,
    dataaddr:   DM_DATA_ADDR
  };

  localparam hartinfo_u HARTINFO_VALUE = hartinfo_u'(HARTINFO_FIELDS);

endpackage

// File: source/apb_req_bridge.sv
// APB slave that turns each APB transfer into one word request and completes it with pready
`timescale 1ns/1ps

module apb_req_bridge
  import bus_pkg::*;
(
  input  logic                  s_soc_clk,
  input  logic                  s_soc_rstn,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [BUS_ADDR_W-1:0] paddr_i,
  input  logic [BUS_DATA_W-1:0] pwdata_i,
  input  logic [BUS_BE_W-1:0]   pstrb_i,
  output logic [BUS_DATA_W-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output per_req_t              req_o,
  output logic                  req_valid_o,
  input  logic                  req_ready_i,
  input  per_resp_t             resp_i,
  input  logic                  resp_valid_i,
  output logic                  resp_ready_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_wait
  } state_e;

  state_e                state_q;
  logic                  pready_q;
  logic                  pslverr_q;
  logic [BUS_DATA_W-1:0] prdata_q;

  // APB keeps address and data stable from setup to the end of access
  assign req_o.addr  = paddr_i;
  assign req_o.we    = pwrite_i;
  assign req_o.be    = pstrb_i;
  assign req_o.wdata = pwdata_i;

  assign req_valid_o  = (state_q == st_issue);
  assign resp_ready_o = (state_q == st_wait);

  // **********************************************************************
  // transfer controller
  // **********************************************************************

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      state_q   <= st_idle;
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
      prdata_q  <= '0;
    end else begin
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
      case (state_q)
        st_idle: begin
          // setup phase seen, request goes out in the first access cycle
          if (psel_i && !penable_i) begin
            state_q <= st_issue;
          end
        end
        st_issue: begin
          if (req_ready_i) begin
            state_q <= st_wait;
          end
        end
        st_wait: begin
          if (resp_valid_i) begin
            prdata_q  <= resp_i.rdata;
            pslverr_q <= resp_i.err;
            pready_q  <= 1'b1;
            state_q   <= st_idle;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  assign prdata_o  = prdata_q;
  assign pready_o  = pready_q;
  assign pslverr_o = pslverr_q;

endmodule

// File: source/req_fifo.sv
// valid/ready FIFO of word requests between the APB bridge and the register bank
`timescale 1ns/1ps

module req_fifo
  import bus_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic     s_soc_clk,
  input  logic     s_soc_rstn,
  input  per_req_t in_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output per_req_t out_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  per_req_t         mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign in_ready_o  = (count_q != CNT_W'(FIFO_DEPTH));
  assign out_valid_o = (count_q != '0);
  // head shown straight from storage
  assign out_o       = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // request storage
  always_ff @(posedge s_soc_clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_i;
    end
  end

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: source/dm_reg_bank.sv
// debug data/scratch register bank with byte enables and a read-only hart-info word
`timescale 1ns/1ps

module dm_reg_bank
  import bus_pkg::*;
  import dbg_pkg::*;
#(
  parameter int unsigned N_DATA_WORDS = 4
) (
  input  logic      s_soc_clk,
  input  logic      s_soc_rstn,
  input  per_req_t  req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  output per_resp_t resp_o,
  output logic      resp_valid_o,
  input  logic      resp_ready_i
);

  localparam int unsigned IDX_W = (N_DATA_WORDS > 1) ? $clog2(N_DATA_WORDS) : 1;

  logic [BUS_DATA_W-1:0] data_q [N_DATA_WORDS];
  logic                  resp_valid_q;
  per_resp_t             resp_q;
  per_resp_t             resp_d;

  logic                  accept;
  logic [29:0]           word_addr;
  logic [29:0]           data_off;
  logic [IDX_W-1:0]      data_idx;
  logic                  data_hit;
  logic                  info_hit;

  // one response held at a time
  assign req_ready_o = !resp_valid_q;
  assign accept      = req_valid_i & req_ready_o;

  // **********************************************************************
  // address decode, word granular
  // **********************************************************************

  assign word_addr = req_i.addr[BUS_ADDR_W-1:2];
  // wraps to a large value below the base, so one compare covers the range
  assign data_off  = word_addr - DATA_BASE_ADDR[31:2];
  assign data_hit  = (data_off < 30'(N_DATA_WORDS));
  assign data_idx  = data_off[IDX_W-1:0];
  assign info_hit  = (word_addr == HARTINFO_ADDR[31:2]);

  always_comb begin
    resp_d.rdata = '0;
    resp_d.err   = 1'b0;
    if (data_hit) begin
      if (!req_i.we) begin
        resp_d.rdata = data_q[data_idx];
      end
    end else if (info_hit) begin
      // hart-info is read only
      if (req_i.we) begin
        resp_d.err = 1'b1;
      end else begin
        resp_d.rdata = HARTINFO_VALUE.raw;
      end
    end else begin
      resp_d.err = 1'b1;
    end
  end

  // **********************************************************************
  // data and scratch words
  // **********************************************************************

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      for (int i = 0; i < N_DATA_WORDS; i++) begin
        data_q[i] <= '0;
      end
    end else if (accept && req_i.we && data_hit) begin
      for (int b = 0; b < BUS_BE_W; b++) begin
        if (req_i.be[b]) begin
          data_q[data_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // response one cycle after accept, held until taken
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge s_soc_clk) begin
    if (accept) begin
      resp_q <= resp_d;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

endmodule

// File: source/dbg_apb_top.sv
// top level of the APB debug-register path: bridge, request FIFO and register bank
`timescale 1ns/1ps

module dbg_apb_top
  import bus_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH   = 2,
  parameter int unsigned N_DATA_WORDS = 4
) (
  input  logic                  s_soc_clk,
  input  logic                  s_soc_rstn,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [BUS_ADDR_W-1:0] paddr_i,
  input  logic [BUS_DATA_W-1:0] pwdata_i,
  input  logic [BUS_BE_W-1:0]   pstrb_i,
  output logic [BUS_DATA_W-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);

  // bridge to FIFO
  per_req_t  br_req;
  logic      br_req_valid;
  logic      br_req_ready;

  // FIFO to bank
  per_req_t  fifo_req;
  logic      fifo_req_valid;
  logic      fifo_req_ready;

  // bank back to bridge
  per_resp_t bank_resp;
  logic      bank_resp_valid;
  logic      bank_resp_ready;

  apb_req_bridge i_apb_req_bridge (
    .s_soc_clk    (s_soc_clk),
    .s_soc_rstn   (s_soc_rstn),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .pstrb_i      (pstrb_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .req_o        (br_req),
    .req_valid_o  (br_req_valid),
    .req_ready_i  (br_req_ready),
    .resp_i       (bank_resp),
    .resp_valid_i (bank_resp_valid),
    .resp_ready_o (bank_resp_ready)
  );

  req_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_req_fifo (
    .s_soc_clk   (s_soc_clk),
    .s_soc_rstn  (s_soc_rstn),
    .in_i        (br_req),
    .in_valid_i  (br_req_valid),
    .in_ready_o  (br_req_ready),
    .out_o       (fifo_req),
    .out_valid_o (fifo_req_valid),
    .out_ready_i (fifo_req_ready)
  );

  dm_reg_bank #(
    .N_DATA_WORDS (N_DATA_WORDS)
  ) i_dm_reg_bank (
    .s_soc_clk    (s_soc_clk),
    .s_soc_rstn   (s_soc_rstn),
    .req_i        (fifo_req),
    .req_valid_i  (fifo_req_valid),
    .req_ready_o  (fifo_req_ready),
    .resp_o       (bank_resp),
    .resp_valid_o (bank_resp_valid),
    .resp_ready_i (bank_resp_ready)
  );

endmodule

// File: testbench/dbg_apb_checker.sv
// concurrent assertions on the APB port and the bridge-to-FIFO handshake, bound into the top level
`timescale 1ns/1ps

module dbg_apb_checker
  import bus_pkg::*;
(
  input logic     s_soc_clk,
  input logic     s_soc_rstn,
  input logic     psel_i,
  input logic     penable_i,
  input logic     pready_i,
  input logic     pslverr_i,
  input per_req_t req_i,
  input logic     req_valid_i,
  input logic     req_ready_i
);

  // pready only in the access phase
  pready_in_access: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    pready_i |-> (psel_i && penable_i))
    else $error("pready high outside an APB access phase");

  pslverr_with_pready: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    pslverr_i |-> pready_i)
    else $error("pslverr high without pready");

  // stalled request keeps valid and payload
  req_held_when_stalled: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    (req_valid_i && !req_ready_i) |=> (req_valid_i && $stable(req_i)))
    else $error("request valid or data changed while stalled");

endmodule

bind dbg_apb_top dbg_apb_checker i_dbg_apb_checker (
  .s_soc_clk   (s_soc_clk),
  .s_soc_rstn  (s_soc_rstn),
  .psel_i      (psel_i),
  .penable_i   (penable_i),
  .pready_i    (pready_o),
  .pslverr_i   (pslverr_o),
  .req_i       (br_req),
  .req_valid_i (br_req_valid),
  .req_ready_i (br_req_ready)
);

// File: testbench/tb_dbg_apb_top.sv
// testbench for the APB debug-register path, runs a table and random APB accesses against a shadow model
`timescale 1ns/1ps

module tb_dbg_apb_top
  import dbg_pkg::*;
();

  localparam int unsigned N_WORDS      = 4;
  localparam int unsigned IDX_W        = $clog2(N_WORDS);
  localparam int unsigned N_RANDOM     = 40;
  localparam logic [31:0] HARTINFO_EXP = 32'h0021_2380;
  localparam logic [31:0] SEED         = 32'he51ba2af;

  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [3:0]  strb;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
  } vec_t;

  logic        s_soc_clk;
  logic        s_soc_rstn;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  vec_t        table_q [$];
  logic [31:0] shadow [N_WORDS];
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 0;
  int unsigned err_cnt;
  int unsigned test_pass;
  int unsigned test_fail;

  dbg_apb_top i_dbg_apb_top (
    .s_soc_clk  (s_soc_clk),
    .s_soc_rstn (s_soc_rstn),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .paddr_i    (paddr),
    .pwdata_i   (pwdata),
    .pstrb_i    (pstrb),
    .prdata_o   (prdata),
    .pready_o   (pready),
    .pslverr_o  (pslverr)
  );

  initial begin
    s_soc_clk = 1'b0;
    forever #5 s_soc_clk = ~s_soc_clk;
  end

  // run limit, armed once the test list is known
  always @(posedge s_soc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // **********************************************************************
  // APB master, setup then access, waits for pready
  // **********************************************************************

  task automatic apb_access(input logic we, input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge s_soc_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = we;
    paddr   = addr;
    pwdata  = wdata;
    pstrb   = strb;
    @(negedge s_soc_clk);
    penable = 1'b1;
    do begin
      @(negedge s_soc_clk);
    end while (!pready);
    rdata = prdata;
    err   = pslverr;
    // transfer completes on the coming rising edge
    @(negedge s_soc_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // shadow of the register map, updates the data words on writes
  task automatic model_access(input logic we, input logic [31:0] addr, input logic [3:0] strb,
                              input logic [31:0] wdata, output logic [31:0] exp_rdata,
                              output logic exp_err);
    logic [31:0]      offset;
    logic [IDX_W-1:0] widx;
    offset    = addr - DATA_BASE_ADDR;
    widx      = offset[IDX_W+1:2];
    exp_rdata = '0;
    exp_err   = 1'b0;
    if (addr >= DATA_BASE_ADDR && offset < 4 * N_WORDS) begin
      if (we) begin
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) begin
            shadow[widx][8*b +: 8] = wdata[8*b +: 8];
          end
        end
      end else begin
        exp_rdata = shadow[widx];
      end
    end else if (addr == HARTINFO_ADDR && !we) begin
      exp_rdata = HARTINFO_EXP;
    end else begin
      exp_err = 1'b1;
    end
  endtask

  task automatic run_test(input int unsigned num, input vec_t v);
    logic [31:0] rdata;
    logic        err;
    int unsigned errs_before;
    errs_before = err_cnt;
    apb_access(v.we, v.addr, v.strb, v.wdata, rdata, err);
    check_val("pslverr", {31'd0, err}, {31'd0, v.exp_err});
    if (!v.we || v.exp_err) begin
      check_val("prdata", rdata, v.exp_rdata);
    end
    if (err_cnt == errs_before) begin
      test_pass++;
      $display("test %0d %s 0x%h passed", num, v.we ? "write" : "read", v.addr);
    end else begin
      test_fail++;
      $display("test %0d %s 0x%h failed", num, v.we ? "write" : "read", v.addr);
    end
  endtask

  task automatic add_vec(input logic we, input logic [31:0] addr, input logic [3:0] strb,
                         input logic [31:0] wdata, input logic [31:0] exp_rdata,
                         input logic exp_err);
    vec_t v;
    v.we        = we;
    v.addr      = addr;
    v.strb      = strb;
    v.wdata     = wdata;
    v.exp_rdata = exp_rdata;
    v.exp_err   = exp_err;
    table_q.push_back(v);
  endtask

  // **********************************************************************
  // stimulus table: we, addr, strb, wdata, expected rdata, expected err
  // **********************************************************************

  task automatic load_table();
    // data words read zero after reset
    for (int i = 0; i < N_WORDS; i++) begin
      add_vec(1'b0, 32'(4 * i), 4'h0, 32'h0, 32'h0, 1'b0);
    end
    add_vec(1'b1, 32'h00, 4'hf, 32'h1122_3344, 32'h0, 1'b0);
    add_vec(1'b1, 32'h04, 4'hf, 32'h5566_7788, 32'h0, 1'b0);
    add_vec(1'b1, 32'h08, 4'hf, 32'h99aa_bbcc, 32'h0, 1'b0);
    add_vec(1'b1, 32'h0c, 4'hf, 32'hddee_ff00, 32'h0, 1'b0);
    add_vec(1'b0, 32'h00, 4'h0, 32'h0, 32'h1122_3344, 1'b0);
    add_vec(1'b0, 32'h04, 4'h0, 32'h0, 32'h5566_7788, 1'b0);
    add_vec(1'b0, 32'h08, 4'h0, 32'h0, 32'h99aa_bbcc, 1'b0);
    add_vec(1'b0, 32'h0c, 4'h0, 32'h0, 32'hddee_ff00, 1'b0);
    // partial strobes, only enabled bytes change
    add_vec(1'b1, 32'h00, 4'h5, 32'ha5a5_a5a5, 32'h0, 1'b0);
    add_vec(1'b1, 32'h04, 4'h8, 32'h0f00_0000, 32'h0, 1'b0);
    add_vec(1'b1, 32'h08, 4'h6, 32'h00de_ad00, 32'h0, 1'b0);
    add_vec(1'b1, 32'h0c, 4'h0, 32'hffff_ffff, 32'h0, 1'b0);
    add_vec(1'b0, 32'h00, 4'h0, 32'h0, 32'h11a5_33a5, 1'b0);
    add_vec(1'b0, 32'h04, 4'h0, 32'h0, 32'h0f66_7788, 1'b0);
    add_vec(1'b0, 32'h08, 4'h0, 32'h0, 32'h99de_adcc, 1'b0);
    add_vec(1'b0, 32'h0c, 4'h0, 32'h0, 32'hddee_ff00, 1'b0);
    // hart-info is read only
    add_vec(1'b0, HARTINFO_ADDR, 4'h0, 32'h0, HARTINFO_EXP, 1'b0);
    add_vec(1'b1, HARTINFO_ADDR, 4'hf, 32'h1234_5678, 32'h0, 1'b1);
    add_vec(1'b0, HARTINFO_ADDR, 4'h0, 32'h0, HARTINFO_EXP, 1'b0);
    // unmapped addresses
    add_vec(1'b0, 32'h44, 4'h0, 32'h0, 32'h0, 1'b1);
    add_vec(1'b1, 32'h44, 4'hf, 32'hdead_beef, 32'h0, 1'b1);
    add_vec(1'b0, 32'h10, 4'h0, 32'h0, 32'h0, 1'b1);
    add_vec(1'b1, 32'h10, 4'hf, 32'hdead_beef, 32'h0, 1'b1);
    add_vec(1'b0, 32'h100, 4'h0, 32'h0, 32'h0, 1'b1);
    add_vec(1'b1, 32'h100, 4'hf, 32'hdead_beef, 32'h0, 1'b1);
    add_vec(1'b0, 32'h00, 4'h0, 32'h0, 32'h11a5_33a5, 1'b0);
    add_vec(1'b0, 32'h04, 4'h0, 32'h0, 32'h0f66_7788, 1'b0);
    add_vec(1'b0, 32'h08, 4'h0, 32'h0, 32'h99de_adcc, 1'b0);
    add_vec(1'b0, 32'h0c, 4'h0, 32'h0, 32'hddee_ff00, 1'b0);
  endtask

  initial begin
    vec_t        v;
    logic [31:0] rnd;
    logic [31:0] exp_rdata;
    logic        exp_err;
    int unsigned num;
    void'($urandom(SEED));
    s_soc_rstn = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    pstrb      = '0;
    err_cnt    = 0;
    test_pass  = 0;
    test_fail  = 0;
    num        = 0;
    for (int i = 0; i < N_WORDS; i++) begin
      shadow[i] = '0;
    end
    load_table();
    cycle_limit = (table_q.size() + N_RANDOM) * 20 + 100;
    repeat (8) @(posedge s_soc_clk);
    @(negedge s_soc_clk);
    s_soc_rstn = 1'b1;

    foreach (table_q[i]) begin
      v = table_q[i];
      // keeps the shadow in step for the random section
      model_access(v.we, v.addr, v.strb, v.wdata, exp_rdata, exp_err);
      run_test(num, v);
      num++;
    end

    // random mix of data words, unmapped words and hart-info
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd    = $urandom;
      v.we   = rnd[0];
      v.strb = v.we ? rnd[4:1] : 4'h0;
      v.addr = (rnd[7:5] == 3'd7) ? HARTINFO_ADDR : DATA_BASE_ADDR + {27'd0, rnd[7:5], 2'b00};
      v.wdata = $urandom;
      model_access(v.we, v.addr, v.strb, v.wdata, exp_rdata, exp_err);
      v.exp_rdata = exp_rdata;
      v.exp_err   = exp_err;
      run_test(num, v);
      num++;
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d", num, test_pass, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
source/bus_pkg.sv
source/dbg_pkg.sv
source/apb_req_bridge.sv
source/req_fifo.sv
source/dm_reg_bank.sv
source/dbg_apb_top.sv
testbench/dbg_apb_checker.sv
testbench/tb_dbg_apb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator from files.f, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_dbg_apb_top \
  -Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx ">>> PASS" "$log_file"; then
  exit 0
fi
exit 1
